/* hw/lat_channel_pkg.sv */
// Shared constants for the latency channel
// Header layout, request type codes, delay ranges and default widths
package lat_channel_pkg;

   // Request header word
   localparam int HDR_W = 32;
   // Type field position in the header
   localparam int TYPE_HI = 31;
   localparam int TYPE_LO = 28;

   // Request type codes
   localparam logic [3:0] REQ_RDLINE = 4'd1;
   localparam logic [3:0] REQ_WRLINE = 4'd2;
   // Fence never reaches the wait slots
   localparam logic [3:0] REQ_WRFENCE = 4'd4;

   // Delay counter width
   localparam int DLY_W = 8;

   // Reads land in 20..35 cycles
   localparam logic [DLY_W-1:0] RD_DLY_BASE = 8'd20;
   localparam logic [DLY_W-1:0] RD_DLY_MASK = 8'd15;

   // Writes land in 10..17 cycles
   localparam logic [DLY_W-1:0] WR_DLY_BASE = 8'd10;
   localparam logic [DLY_W-1:0] WR_DLY_MASK = 8'd7;

   // Fixed delay for unknown types
   localparam logic [DLY_W-1:0] UNDEF_DLY = 8'd5;

   // Delay LFSR start value, must be nonzero
   localparam logic [15:0] LFSR_SEED = 16'hace1;

   // Sequence tag stamped on every write
   localparam int TAG_W = 16;

endpackage

/* hw/sync_fifo.sv */
// Show-ahead synchronous FIFO
// Almost-full threshold, one-cycle overflow and underflow flags
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH      = 64,
   parameter int DEPTH_LOG2 = 3,
   parameter int ALMFULL    = 6
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             wr_en_i,
   input  logic [WIDTH-1:0] din_i,
   input  logic             rd_en_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             valid_o,
   output logic             almfull_o,
   output logic             empty_o,
   output logic             overflow_o,
   output logic             underflow_o
);

   localparam logic [DEPTH_LOG2:0] FULL_LVL = (DEPTH_LOG2+1)'(2 ** DEPTH_LOG2);
   localparam logic [DEPTH_LOG2:0] ALM_LVL  = (DEPTH_LOG2+1)'(ALMFULL);

   logic [WIDTH-1:0]      mem [2 ** DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full    = (count == FULL_LVL);
   assign empty_o = (count == '0);
   assign valid_o = !empty_o;
   // Almost full when occupancy reaches the threshold
   assign almfull_o = (count >= ALM_LVL);
   // Head is visible without a read
   assign dout_o = mem[rd_ptr];

   // Illegal accesses are dropped
   assign do_wr = wr_en_i && !full;
   assign do_rd = rd_en_i && !empty_o;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Occupancy only moves on a lone write or a lone read
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One-cycle error pulses
         overflow_o  <= wr_en_i && full;
         underflow_o <= rd_en_i && empty_o;
      end
   end

endmodule

/* hw/fence_gate.sv */
// Gate between the input FIFO and the wait slots
// Traps write fences until drained, forwards other requests as a strobe
`timescale 1ns/1ps

module fence_gate import lat_channel_pkg::*; #(
   parameter int DATA_W = 64
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid_i,
   input  logic [TAG_W-1:0]  in_tag_i,
   input  logic [HDR_W-1:0]  in_hdr_i,
   input  logic [DATA_W-1:0] in_data_i,
   output logic              pop_o,
   input  logic              slots_almfull_i,
   input  logic              drained_i,
   output logic              req_valid_o,
   output logic [TAG_W-1:0]  req_tag_o,
   output logic [HDR_W-1:0]  req_hdr_o,
   output logic [DATA_W-1:0] req_data_o
);

   // Gate FSM states
   localparam logic [1:0] ST_PASS   = 2'd0;
   localparam logic [1:0] ST_FENCE  = 2'd1;
   localparam logic [1:0] ST_SETTLE = 2'd2;

   logic [1:0] state;
   logic [3:0] head_type;
   logic       head_fence;
   logic       pass_pop;
   logic       fence_pop;

   assign head_type  = in_hdr_i[TYPE_HI:TYPE_LO];
   assign head_fence = in_valid_i && (head_type == REQ_WRFENCE);

   // Normal request moves on while slots have room
   assign pass_pop  = (state == ST_PASS) && in_valid_i && !head_fence && !slots_almfull_i;
   // Fence is dropped once slots and output FIFO are empty
   assign fence_pop = (state == ST_FENCE) && drained_i;
   assign pop_o     = pass_pop || fence_pop;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= ST_PASS;
         req_valid_o <= 1'b0;
      end else begin
         req_valid_o <= pass_pop;
         case (state)
            ST_PASS: begin
               if (head_fence) begin
                  state <= ST_FENCE;
               end
            end
            ST_FENCE: begin
               if (drained_i) begin
                  state <= ST_SETTLE;
               end
            end
            // One bubble while the FIFO head moves past the fence
            ST_SETTLE: state <= ST_PASS;
            default:   state <= ST_PASS;
         endcase
      end
   end

   // Request register, one cycle behind the pop
   always_ff @(posedge clk) begin
      if (pass_pop) begin
         req_tag_o  <= in_tag_i;
         req_hdr_o  <= in_hdr_i;
         req_data_o <= in_data_i;
      end
   end

endmodule

/* hw/delay_picker.sv */
// Pseudo-random delay source
// Galois LFSR masked into the range of each request type
`timescale 1ns/1ps

module delay_picker import lat_channel_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic [3:0]       type_i,
   output logic [DLY_W-1:0] delay_o
);

   // x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [15:0] LFSR_TAPS = 16'hb400;

   logic [15:0]      lfsr;
   logic [DLY_W-1:0] rnd;

   // Free-running, one step per cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= LFSR_SEED;
      end else if (lfsr[0]) begin
         lfsr <= {1'b0, lfsr[15:1]} ^ LFSR_TAPS;
      end else begin
         lfsr <= {1'b0, lfsr[15:1]};
      end
   end

   assign rnd = lfsr[DLY_W-1:0];

   // Base plus masked random bits
   always_comb begin
      case (type_i)
         REQ_RDLINE: delay_o = RD_DLY_BASE + (rnd & RD_DLY_MASK);
         REQ_WRLINE: delay_o = WR_DLY_BASE + (rnd & WR_DLY_MASK);
         default:    delay_o = UNDEF_DLY;
      endcase
   end

endmodule

/* hw/latency_slots.sv */
// Wait-slot array for the latency channel
// Rotating free-slot search, per-slot countdown, rotating release of ready slots
`timescale 1ns/1ps

module latency_slots import lat_channel_pkg::*; #(
   parameter int DATA_W    = 64,
   parameter int NUM_SLOTS = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              req_valid_i,
   input  logic [TAG_W-1:0]  req_tag_i,
   input  logic [HDR_W-1:0]  req_hdr_i,
   input  logic [DATA_W-1:0] req_data_i,
   output logic              almfull_o,
   output logic              empty_o,
   input  logic              out_almfull_i,
   output logic              rel_valid_o,
   output logic [TAG_W-1:0]  rel_tag_o,
   output logic [HDR_W-1:0]  rel_hdr_o,
   output logic [DATA_W-1:0] rel_data_o
);

   localparam int SLOT_W = $clog2(NUM_SLOTS);
   localparam logic [SLOT_W:0] ALL_FREE = (SLOT_W+1)'(NUM_SLOTS);

   // Slot states
   localparam logic [1:0] SL_FREE  = 2'd0;
   localparam logic [1:0] SL_COUNT = 2'd1;
   localparam logic [1:0] SL_READY = 2'd2;

   logic [1:0]          slot_st   [NUM_SLOTS];
   logic [DLY_W-1:0]    slot_cnt  [NUM_SLOTS];
   logic [TAG_W-1:0]    slot_tag  [NUM_SLOTS];
   logic [HDR_W-1:0]    slot_hdr  [NUM_SLOTS];
   logic [DATA_W-1:0]   slot_data [NUM_SLOTS];
   logic [NUM_SLOTS-1:0] free_vec;
   logic [NUM_SLOTS-1:0] ready_vec;
   logic [SLOT_W:0]     free_cnt;
   logic [SLOT_W-1:0]   push_ptr;
   logic [SLOT_W-1:0]   pop_ptr;
   logic [SLOT_W:0]     push_res;
   logic [SLOT_W:0]     pop_res;
   logic [SLOT_W-1:0]   push_idx;
   logic [SLOT_W-1:0]   pop_idx;
   logic                push_found;
   logic                pop_found;
   logic                do_push;
   logic                do_release;
   logic [DLY_W-1:0]    new_dly;

   // First hit after the last slot used, wrapping around
   function automatic logic [SLOT_W:0] find_slot(input logic [NUM_SLOTS-1:0] hit,
                                                 input logic [SLOT_W-1:0] last);
      logic [SLOT_W:0] res;
      int              pos;
      res = '0;
      // Walk backwards so the nearest hit is kept
      for (int i = NUM_SLOTS; i >= 1; i--) begin
         pos = int'(last) + i;
         if (pos >= NUM_SLOTS) begin
            pos = pos - NUM_SLOTS;
         end
         if (hit[pos]) begin
            res = {1'b1, SLOT_W'(pos)};
         end
      end
      return res;
   endfunction

   delay_picker delay_picker_i (
      .clk     (clk),
      .rst     (rst),
      .type_i  (req_hdr_i[TYPE_HI:TYPE_LO]),
      .delay_o (new_dly)
   );

   always_comb begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
         free_vec[s]  = (slot_st[s] == SL_FREE);
         ready_vec[s] = (slot_st[s] == SL_READY);
      end
   end

   assign free_cnt = (SLOT_W+1)'($countones(free_vec));
   // Room for at most one more request
   assign almfull_o = (free_cnt <= (SLOT_W+1)'(1));
   // Nothing held and nothing on its way to the output FIFO
   assign empty_o = (free_cnt == ALL_FREE) && !rel_valid_o;

   // Found flag on top, slot index below
   assign push_res   = find_slot(free_vec, push_ptr);
   assign pop_res    = find_slot(ready_vec, pop_ptr);
   assign push_found = push_res[SLOT_W];
   assign pop_found  = pop_res[SLOT_W];
   assign push_idx   = push_res[SLOT_W-1:0];
   assign pop_idx    = pop_res[SLOT_W-1:0];

   assign do_push    = req_valid_i && push_found;
   // Release holds off while the output FIFO is nearly full
   assign do_release = pop_found && !out_almfull_i;

   // Slot states and search pointers
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < NUM_SLOTS; s++) begin
            slot_st[s] <= SL_FREE;
         end
         push_ptr    <= '0;
         pop_ptr     <= '0;
         rel_valid_o <= 1'b0;
      end else begin
         // Countdown done
         for (int s = 0; s < NUM_SLOTS; s++) begin
            if (slot_st[s] == SL_COUNT && slot_cnt[s] == '0) begin
               slot_st[s] <= SL_READY;
            end
         end
         if (do_push) begin
            slot_st[push_idx] <= SL_COUNT;
            push_ptr          <= push_idx;
         end
         if (do_release) begin
            slot_st[pop_idx] <= SL_FREE;
            pop_ptr          <= pop_idx;
         end
         rel_valid_o <= do_release;
      end
   end

   // Counters and payload
   always_ff @(posedge clk) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
         if (slot_st[s] == SL_COUNT && slot_cnt[s] != '0) begin
            slot_cnt[s] <= slot_cnt[s] - 1'b1;
         end
      end
      if (do_push) begin
         slot_cnt[push_idx]  <= new_dly;
         slot_tag[push_idx]  <= req_tag_i;
         slot_hdr[push_idx]  <= req_hdr_i;
         slot_data[push_idx] <= req_data_i;
      end
      // Released request registered toward the output FIFO
      if (do_release) begin
         rel_tag_o  <= slot_tag[pop_idx];
         rel_hdr_o  <= slot_hdr[pop_idx];
         rel_data_o <= slot_data[pop_idx];
      end
   end

endmodule

/* hw/ooo_latency_channel.sv */
// Out-of-order latency channel top level
// Request tagging, input FIFO, fence gate, wait slots, output FIFO
`timescale 1ns/1ps

module ooo_latency_channel import lat_channel_pkg::*; #(
   parameter int DATA_W         = 64,
   parameter int NUM_SLOTS      = 8,
   parameter int IN_DEPTH_LOG2  = 4,
   parameter int OUT_DEPTH_LOG2 = 3,
   parameter int IN_ALMFULL     = 12,
   parameter int OUT_ALMFULL    = 6
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              write_i,
   input  logic [HDR_W-1:0]  hdr_i,
   input  logic [DATA_W-1:0] data_i,
   output logic              full_o,
   output logic              valid_o,
   input  logic              read_i,
   output logic [TAG_W-1:0]  tag_o,
   output logic [HDR_W-1:0]  hdr_o,
   output logic [DATA_W-1:0] data_o,
   output logic              empty_o,
   output logic              overflow_o,
   output logic              underflow_o
);

   // Tag, header, data
   localparam int WORD_W = TAG_W + HDR_W + DATA_W;

   logic [TAG_W-1:0]  tag_cnt;
   logic              in_valid;
   logic              in_pop;
   logic [TAG_W-1:0]  in_tag;
   logic [HDR_W-1:0]  in_hdr;
   logic [DATA_W-1:0] in_data;
   logic              in_ovf;
   logic              in_unf;
   logic              req_valid;
   logic [TAG_W-1:0]  req_tag;
   logic [HDR_W-1:0]  req_hdr;
   logic [DATA_W-1:0] req_data;
   logic              slots_almfull;
   logic              slots_empty;
   logic              drained;
   logic              rel_valid;
   logic [TAG_W-1:0]  rel_tag;
   logic [HDR_W-1:0]  rel_hdr;
   logic [DATA_W-1:0] rel_data;
   logic              out_almfull;
   logic              out_ovf;
   logic              out_unf;

   // Every write gets the next tag, fences too
   always_ff @(posedge clk) begin
      if (rst) begin
         tag_cnt <= '0;
      end else if (write_i) begin
         tag_cnt <= tag_cnt + 1'b1;
      end
   end

   // Burst staging
   sync_fifo #(
      .WIDTH      (WORD_W),
      .DEPTH_LOG2 (IN_DEPTH_LOG2),
      .ALMFULL    (IN_ALMFULL)
   ) in_fifo_i (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (write_i),
      .din_i       ({tag_cnt, hdr_i, data_i}),
      .rd_en_i     (in_pop),
      .dout_o      ({in_tag, in_hdr, in_data}),
      .valid_o     (in_valid),
      .almfull_o   (full_o),
      .empty_o     (),
      .overflow_o  (in_ovf),
      .underflow_o (in_unf)
   );

   // Fence waits on everything ahead of it
   assign drained = slots_empty && empty_o;

   fence_gate #(
      .DATA_W (DATA_W)
   ) fence_gate_i (
      .clk             (clk),
      .rst             (rst),
      .in_valid_i      (in_valid),
      .in_tag_i        (in_tag),
      .in_hdr_i        (in_hdr),
      .in_data_i       (in_data),
      .pop_o           (in_pop),
      .slots_almfull_i (slots_almfull),
      .drained_i       (drained),
      .req_valid_o     (req_valid),
      .req_tag_o       (req_tag),
      .req_hdr_o       (req_hdr),
      .req_data_o      (req_data)
   );

   latency_slots #(
      .DATA_W    (DATA_W),
      .NUM_SLOTS (NUM_SLOTS)
   ) latency_slots_i (
      .clk           (clk),
      .rst           (rst),
      .req_valid_i   (req_valid),
      .req_tag_i     (req_tag),
      .req_hdr_i     (req_hdr),
      .req_data_i    (req_data),
      .almfull_o     (slots_almfull),
      .empty_o       (slots_empty),
      .out_almfull_i (out_almfull),
      .rel_valid_o   (rel_valid),
      .rel_tag_o     (rel_tag),
      .rel_hdr_o     (rel_hdr),
      .rel_data_o    (rel_data)
   );

   // Released requests, now out of order
   sync_fifo #(
      .WIDTH      (WORD_W),
      .DEPTH_LOG2 (OUT_DEPTH_LOG2),
      .ALMFULL    (OUT_ALMFULL)
   ) out_fifo_i (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (rel_valid),
      .din_i       ({rel_tag, rel_hdr, rel_data}),
      .rd_en_i     (read_i),
      .dout_o      ({tag_o, hdr_o, data_o}),
      .valid_o     (valid_o),
      .almfull_o   (out_almfull),
      .empty_o     (empty_o),
      .overflow_o  (out_ovf),
      .underflow_o (out_unf)
   );

   assign overflow_o  = in_ovf || out_ovf;
   assign underflow_o = in_unf || out_unf;

endmodule

/* bench/ooo_latency_channel_assert.sv */
// Concurrent checks on the latency channel outputs
// Bound into the top level
`timescale 1ns/1ps

module ooo_latency_channel_assert import lat_channel_pkg::*; (
   input logic             clk,
   input logic             rst,
   input logic             valid_i,
   input logic             empty_i,
   input logic             read_i,
   input logic [TAG_W-1:0] tag_i,
   input logic             full_i,
   input logic             overflow_i,
   input logic             underflow_i
);

   // Valid mirrors the empty flag
   valid_empty_a: assert property (@(posedge clk) disable iff (rst) valid_i == !empty_i)
      else $error("valid_o and empty_o disagree");

   // Head holds until it is read
   tag_hold_a: assert property (@(posedge clk) disable iff (rst)
      valid_i && !read_i |=> $stable(tag_i))
      else $error("tag_o changed without a read");

   // Quiet outputs while reset is held
   reset_quiet_a: assert property (@(posedge clk)
      rst && $past(rst) |-> !valid_i && !full_i && !overflow_i && !underflow_i)
      else $error("status flag high during reset");

endmodule

bind ooo_latency_channel ooo_latency_channel_assert ooo_latency_channel_assert_i (
   .clk         (clk),
   .rst         (rst),
   .valid_i     (valid_o),
   .empty_i     (empty_o),
   .read_i      (read_i),
   .tag_i       (tag_o),
   .full_i      (full_o),
   .overflow_i  (overflow_o),
   .underflow_i (underflow_o)
);

/* bench/ooo_latency_channel_tb.sv */
// Directed testbench for the out-of-order latency channel
// Clock, reset, LCG stimulus, tag scoreboard and one task per test
`timescale 1ns/1ps

module ooo_latency_channel_tb import lat_channel_pkg::*; ();

   localparam int DATA_W   = 64;
   // Per-item wait limit in cycles
   localparam int WAIT_MAX = 200;

   logic              clk = 1'b0;
   logic              rst;
   logic              write_i;
   logic [HDR_W-1:0]  hdr_i;
   logic [DATA_W-1:0] data_i;
   logic              read_i;
   logic              full_o;
   logic              valid_o;
   logic [TAG_W-1:0]  tag_o;
   logic [HDR_W-1:0]  hdr_o;
   logic [DATA_W-1:0] data_o;
   logic              empty_o;
   logic              overflow_o;
   logic              underflow_o;

   // Scoreboard indexed by tag
   logic [HDR_W-1:0]  exp_hdr  [256];
   logic [DATA_W-1:0] exp_data [256];
   logic              pending  [256];
   int                next_tag;
   // Tag of the fence under test, negative when none
   int                barrier_tag;
   logic [31:0]       lcg_state;

   ooo_latency_channel #(
      .DATA_W (DATA_W)
   ) ooo_latency_channel_i (
      .clk         (clk),
      .rst         (rst),
      .write_i     (write_i),
      .hdr_i       (hdr_i),
      .data_i      (data_i),
      .full_o      (full_o),
      .valid_o     (valid_o),
      .read_i      (read_i),
      .tag_o       (tag_o),
      .hdr_o       (hdr_o),
      .data_o      (data_o),
      .empty_o     (empty_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   always #5 clk = ~clk;

   task automatic report_mismatch(input string test, input string what,
                                  input logic [63:0] exp, input logic [63:0] act);
      $display("FAIL %s: %s expected %h, actual %h", test, what, exp, act);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "run aborted");
   endtask

   // Numerical Recipes LCG step
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Read, write or undefined type with a random address
   function automatic logic [HDR_W-1:0] random_hdr();
      logic [31:0] r;
      logic [3:0]  kind;
      r = next_random();
      case (r % 32'd3)
         32'd0:   kind = REQ_RDLINE;
         32'd1:   kind = REQ_WRLINE;
         // Code outside the defined set
         default: kind = 4'hb;
      endcase
      r = next_random();
      return {kind, r[27:0]};
   endfunction

   // One write strobe, fences are not expected back
   task automatic drive_write(input logic [HDR_W-1:0] hdr, input logic [DATA_W-1:0] data);
      @(posedge clk);
      write_i <= 1'b1;
      hdr_i   <= hdr;
      data_i  <= data;
      if (hdr[TYPE_HI:TYPE_LO] != REQ_WRFENCE) begin
         exp_hdr[next_tag]  = hdr;
         exp_data[next_tag] = data;
         pending[next_tag]  = 1'b1;
      end
      next_tag++;
   endtask

   // Writer that honours full_o
   task automatic send(input logic [HDR_W-1:0] hdr, input logic [DATA_W-1:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      while (full_o) begin
         waited++;
         if (waited > WAIT_MAX) begin
            abort_run("Timeout: full_o stayed high and the writer could not continue");
         end
         @(negedge clk);
      end
      drive_write(hdr, data);
   endtask

   task automatic send_random();
      send(random_hdr(), {next_random(), next_random()});
   endtask

   task automatic end_writes();
      @(posedge clk);
      write_i <= 1'b0;
   endtask

   // Wait for the head, check it, then pop it
   task automatic receive_one(input string test);
      int waited;
      int idx;
      waited = 0;
      @(negedge clk);
      while (!valid_o) begin
         waited++;
         if (waited > WAIT_MAX) begin
            abort_run($sformatf("Timeout in %s: no request came out", test));
         end
         @(negedge clk);
      end
      idx = int'(tag_o);
      assert (idx < 256 && pending[idx]) else
         abort_run($sformatf("%s: tag %0d was never sent or came out twice", test, idx));
      // Nothing behind the fence may pass the requests ahead of it
      if (barrier_tag >= 0 && idx > barrier_tag) begin
         for (int t = 0; t < barrier_tag; t++) begin
            assert (!pending[t]) else
               abort_run($sformatf("%s: tag %0d overtook tag %0d across the fence",
                                   test, idx, t));
         end
      end
      assert (hdr_o == exp_hdr[idx]) else
         report_mismatch(test, "header", 64'(exp_hdr[idx]), 64'(hdr_o));
      assert (data_o == exp_data[idx]) else
         report_mismatch(test, "data", exp_data[idx], data_o);
      pending[idx] = 1'b0;
      @(posedge clk);
      read_i <= 1'b1;
      @(posedge clk);
      read_i <= 1'b0;
   endtask

   task automatic drain(input int n, input string test);
      repeat (n) begin
         receive_one(test);
      end
   endtask

   task automatic check_all_returned(input string test);
      for (int t = 0; t < next_tag; t++) begin
         assert (!pending[t]) else
            abort_run($sformatf("%s: tag %0d never came out", test, t));
      end
   endtask

   task automatic reset_state();
      @(negedge clk);
      assert (empty_o === 1'b1) else report_mismatch("reset", "empty_o", 64'd1, 64'(empty_o));
      assert (valid_o === 1'b0) else report_mismatch("reset", "valid_o", 64'd0, 64'(valid_o));
      assert (full_o === 1'b0) else report_mismatch("reset", "full_o", 64'd0, 64'(full_o));
      assert (overflow_o === 1'b0) else
         report_mismatch("reset", "overflow_o", 64'd0, 64'(overflow_o));
      assert (underflow_o === 1'b0) else
         report_mismatch("reset", "underflow_o", 64'd0, 64'(underflow_o));
   endtask

   // Lone read, latency bounded by the read delay range
   task automatic single_read();
      int cycles;
      send({REQ_RDLINE, 28'h0123_456}, 64'hdead_beef_0bad_f00d);
      end_writes();
      cycles = 0;
      @(negedge clk);
      while (!valid_o) begin
         cycles++;
         if (cycles > int'(RD_DLY_BASE) + int'(RD_DLY_MASK) + 16) begin
            abort_run("Timeout in single_read: the read request came out too late");
         end
         @(negedge clk);
      end
      assert (cycles >= int'(RD_DLY_BASE) + 3) else
         abort_run("single_read: the read request came out before its delay");
      assert (tag_o == '0) else report_mismatch("single_read", "tag", 64'd0, 64'(tag_o));
      receive_one("single_read");
   endtask

   task automatic mixed_traffic();
      fork
         begin
            repeat (20) begin
               send_random();
            end
            end_writes();
         end
         drain(20, "mixed");
      join
      check_all_returned("mixed");
   endtask

   // Two batches split by a write fence
   task automatic fence_order();
      fork
         begin
            repeat (6) begin
               send_random();
            end
            barrier_tag = next_tag;
            send({REQ_WRFENCE, 28'h0}, '0);
            repeat (6) begin
               send_random();
            end
            end_writes();
         end
         drain(12, "fence");
      join
      barrier_tag = -1;
      // Fence itself must stay trapped
      repeat (20) begin
         @(negedge clk);
         assert (!valid_o) else abort_run("fence: an extra request came out after the drain");
      end
      check_all_returned("fence");
   endtask

   // Back-pressure until the input side reports almost full
   task automatic fill_then_drain();
      int sent;
      sent = 0;
      @(negedge clk);
      while (!full_o) begin
         assert (!overflow_o) else abort_run("fill: overflow_o rose while full_o was honoured");
         assert (sent < 64) else abort_run("fill: full_o did not rise after 64 writes");
         drive_write(random_hdr(), {next_random(), next_random()});
         sent++;
         @(negedge clk);
      end
      end_writes();
      repeat (10) begin
         @(negedge clk);
         assert (!overflow_o) else abort_run("fill: overflow_o rose while full_o was honoured");
      end
      drain(sent, "fill");
      check_all_returned("fill");
   endtask

   task automatic empty_read();
      @(negedge clk);
      assert (empty_o) else abort_run("underflow: output FIFO was not empty before the read");
      @(posedge clk);
      read_i <= 1'b1;
      @(posedge clk);
      read_i <= 1'b0;
      @(negedge clk);
      assert (underflow_o === 1'b1) else
         report_mismatch("underflow", "underflow_o", 64'd1, 64'(underflow_o));
      @(negedge clk);
      // Flag is a single-cycle pulse
      assert (underflow_o === 1'b0) else
         report_mismatch("underflow", "underflow_o", 64'd0, 64'(underflow_o));
   endtask

   initial begin
      rst         = 1'b1;
      write_i     = 1'b0;
      hdr_i       = '0;
      data_i      = '0;
      read_i      = 1'b0;
      lcg_state   = 32'h12ea_c843;
      next_tag    = 0;
      barrier_tag = -1;
      for (int t = 0; t < 256; t++) begin
         pending[t] = 1'b0;
      end
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      reset_state();
      single_read();
      mixed_traffic();
      fence_order();
      fill_then_drain();
      empty_read();
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* ooo_latency_channel.f */
hw/lat_channel_pkg.sv
hw/sync_fifo.sv
hw/fence_gate.sv
hw/delay_picker.sv
hw/latency_slots.sv
hw/ooo_latency_channel.sv
bench/ooo_latency_channel_assert.sv
bench/ooo_latency_channel_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the latency channel testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f ooo_latency_channel.f \
   --top-module ooo_latency_channel_tb \
   -o ooo_latency_channel_sim

# The log decides the result
./obj_dir/ooo_latency_channel_sim 2>&1 | tee "$LOG"

if grep -q "Finished with errors" "$LOG" || ! grep -q "Finished with no errors" "$LOG"; then
   echo "Simulation failed, see $LOG"
   exit 1
fi
echo "Simulation passed"
